/* rtl/spi_cmd_pkg.sv */
package spi_cmd_pkg;

  // group opcodes compare only the upper nibble
  localparam logic [7:0] op_set_addr_grp   = 8'h00;
  localparam logic [7:0] op_rom_mask_grp   = 8'h10;
  localparam logic [7:0] op_save_mask_grp  = 8'h20;
  localparam logic [7:0] op_set_mapper_grp = 8'h30;
  localparam logic [7:0] op_sram_read_grp  = 8'h80;
  localparam logic [7:0] op_sram_write_grp = 8'h90;

  // full opcodes
  localparam logic [7:0] op_dspx_addr_rst = 8'he8;
  localparam logic [7:0] op_dspx_pgm_wr   = 8'he9;
  localparam logic [7:0] op_dspx_dat_wr   = 8'hea;
  localparam logic [7:0] op_dspx_reset    = 8'heb;
  localparam logic [7:0] op_featurebits   = 8'hed;
  localparam logic [7:0] op_region        = 8'hee;
  localparam logic [7:0] op_signature     = 8'hf0;
  localparam logic [7:0] op_echo          = 8'hff;

  localparam logic [7:0] signature_byte = 8'ha5;

  // byte positions within a transaction
  localparam int unsigned pos_cmd  = 1;
  localparam int unsigned pos_prm1 = 2;
  localparam int unsigned pos_prm2 = 3;
  localparam int unsigned pos_prm3 = 4;
  localparam int unsigned pos_prm4 = 5;
  localparam int unsigned pos_prm5 = 6;

  // command byte as a whole opcode or split into fields
  typedef union packed {
    logic [7:0] opcode;
    struct packed {
      struct packed {
        logic [2:0] kind;
        logic       no_skip;
      } group;
      logic       autoinc;
      logic [2:0] arg;
    } fields;
  } spi_cmd_u;

endpackage

/* rtl/cart_map_pkg.sv */
package cart_map_pkg;

  localparam int unsigned sram_addr_w = 24;
  localparam int unsigned dspx_addr_w = 11;

  // cartridge mapping configuration
  typedef struct packed {
    logic [2:0]             mapper;
    logic [sram_addr_w-1:0] rom_mask;
    logic [sram_addr_w-1:0] save_mask;
    logic [7:0]             featurebits;
  } cart_cfg_t;

  // dsp program and data memory load ports
  typedef struct packed {
    logic [23:0]            pgm_data;
    logic [dspx_addr_w-1:0] pgm_addr;
    logic                   pgm_we;
    logic [15:0]            dat_data;
    logic [dspx_addr_w-1:0] dat_addr;
    logic                   dat_we;
  } dspx_load_t;

endpackage

/* rtl/cart_config_regs.sv */
`timescale 1ns/1ps

module cart_config_regs
  import spi_cmd_pkg::*;
  import cart_map_pkg::*;
#(
  parameter int byte_cnt_w = 32
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  cmd_ready,
  input  logic                  param_ready,
  input  spi_cmd_u              cmd_data,
  input  logic [7:0]            param_data,
  input  logic [byte_cnt_w-1:0] spi_byte_cnt,
  output cart_cfg_t             cfg,
  output logic                  region,
  output logic                  dspx_reset
);

  logic is_rom_mask;
  logic is_save_mask;

  assign is_rom_mask  = cmd_data.fields.group == op_rom_mask_grp[7:4];
  assign is_save_mask = cmd_data.fields.group == op_save_mask_grp[7:4];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cfg        <= '0;
      cfg.mapper <= 3'd1;
      region     <= 1'b0;
      dspx_reset <= 1'b1;
    end else if (cmd_ready) begin
      if (cmd_data.fields.group == op_set_mapper_grp[7:4]) begin
        cfg.mapper <= cmd_data.fields.arg;
      end
    end else if (param_ready) begin
      // masks arrive msb first
      if (is_rom_mask) begin
        case (spi_byte_cnt)
          byte_cnt_w'(pos_prm1): cfg.rom_mask[23:16] <= param_data;
          byte_cnt_w'(pos_prm2): cfg.rom_mask[15:8]  <= param_data;
          byte_cnt_w'(pos_prm3): cfg.rom_mask[7:0]   <= param_data;
          default: ;
        endcase
      end
      if (is_save_mask) begin
        case (spi_byte_cnt)
          byte_cnt_w'(pos_prm1): cfg.save_mask[23:16] <= param_data;
          byte_cnt_w'(pos_prm2): cfg.save_mask[15:8]  <= param_data;
          byte_cnt_w'(pos_prm3): cfg.save_mask[7:0]   <= param_data;
          default: ;
        endcase
      end
      case (cmd_data.opcode)
        op_dspx_reset:  dspx_reset      <= param_data[0];
        op_featurebits: cfg.featurebits <= param_data;
        op_region:      region          <= param_data[0];
        default: ;
      endcase
    end
  end

endmodule

/* rtl/sram_access_ctrl.sv */
`timescale 1ns/1ps

module sram_access_ctrl
  import spi_cmd_pkg::*;
  import cart_map_pkg::*;
#(
  parameter int byte_cnt_w = 32
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   cmd_ready,
  input  logic                   param_ready,
  input  spi_cmd_u               cmd_data,
  input  logic [7:0]             param_data,
  input  logic [byte_cnt_w-1:0]  spi_byte_cnt,
  input  logic                   mcu_rq_rdy,
  output logic [sram_addr_w-1:0] addr_out,
  output logic                   mcu_rrq,
  output logic                   mcu_wrq,
  output logic [7:0]             mcu_data_out,
  output logic                   sram_data_valid
);

  logic [1:0]            rdy_sr;
  logic                  nextaddr;
  logic                  is_read;
  logic                  is_write;
  logic [byte_cnt_w-1:0] min_cnt;

  assign is_read  = cmd_data.fields.group == op_sram_read_grp[7:4];
  assign is_write = cmd_data.fields.group == op_sram_write_grp[7:4];

  ////////////////////////////////////////////////////
  // ready edge detect
  ////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rdy_sr <= 2'b00;
    end else begin
      rdy_sr <= {rdy_sr[0], mcu_rq_rdy};
    end
  end

  assign nextaddr        = rdy_sr[0] & ~rdy_sr[1];
  assign sram_data_valid = nextaddr & is_read;

  // no_skip holds off the increment for the command byte
  assign min_cnt = byte_cnt_w'(pos_cmd) + byte_cnt_w'(cmd_data.fields.group.no_skip);

  ////////////////////////////////////////////////////
  // address counter
  ////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      addr_out <= '0;
    end else if (param_ready && cmd_data.fields.group == op_set_addr_grp[7:4]) begin
      case (spi_byte_cnt)
        byte_cnt_w'(pos_prm1): addr_out <= {param_data, 16'h0000};
        byte_cnt_w'(pos_prm2): addr_out[15:8] <= param_data;
        byte_cnt_w'(pos_prm3): addr_out[7:0]  <= param_data;
        default: ;
      endcase
    end else if (nextaddr && cmd_data.fields.group.kind == op_sram_read_grp[7:5]
                 && cmd_data.fields.autoinc && spi_byte_cnt >= min_cnt) begin
      addr_out <= addr_out + 1'b1;
    end
  end

  // request pulses and write data
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mcu_rrq      <= 1'b0;
      mcu_wrq      <= 1'b0;
      mcu_data_out <= 8'h00;
    end else begin
      mcu_rrq <= (cmd_ready | param_ready) & is_read;
      mcu_wrq <= param_ready & is_write;
      if (param_ready && is_write) begin
        mcu_data_out <= param_data;
      end
    end
  end

endmodule

/* rtl/dspx_loader.sv */
`timescale 1ns/1ps

module dspx_loader
  import spi_cmd_pkg::*;
  import cart_map_pkg::*;
#(
  parameter int byte_cnt_w = 32
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  param_ready,
  input  spi_cmd_u              cmd_data,
  input  logic [7:0]            param_data,
  input  logic [byte_cnt_w-1:0] spi_byte_cnt,
  output dspx_load_t            dspx
);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      dspx <= '0;
    end else if (param_ready) begin
      case (cmd_data.opcode)
        op_dspx_addr_rst: begin
          if (spi_byte_cnt == byte_cnt_w'(pos_prm1)) begin
            dspx.pgm_addr <= '0;
            dspx.dat_addr <= '0;
          end
        end

        ////////////////////////////////////////////////////
        // 24-bit program word sent msb first
        ////////////////////////////////////////////////////
        op_dspx_pgm_wr: begin
          case (spi_byte_cnt)
            byte_cnt_w'(pos_prm1): dspx.pgm_data[23:16] <= param_data;
            byte_cnt_w'(pos_prm2): dspx.pgm_data[15:8]  <= param_data;
            byte_cnt_w'(pos_prm3): dspx.pgm_data[7:0]   <= param_data;
            byte_cnt_w'(pos_prm4): dspx.pgm_we <= 1'b1;
            byte_cnt_w'(pos_prm5): begin
              dspx.pgm_we   <= 1'b0;
              dspx.pgm_addr <= dspx.pgm_addr + 1'b1;
            end
            default: ;
          endcase
        end

        ////////////////////////////////////////////////////
        // 16-bit data word sent msb first
        ////////////////////////////////////////////////////
        op_dspx_dat_wr: begin
          case (spi_byte_cnt)
            byte_cnt_w'(pos_prm1): dspx.dat_data[15:8] <= param_data;
            byte_cnt_w'(pos_prm2): dspx.dat_data[7:0]  <= param_data;
            byte_cnt_w'(pos_prm3): dspx.dat_we <= 1'b1;
            byte_cnt_w'(pos_prm4): begin
              dspx.dat_we   <= 1'b0;
              dspx.dat_addr <= dspx.dat_addr + 1'b1;
            end
            default: ;
          endcase
        end

        default: ;
      endcase
    end
  end

endmodule

/* rtl/spi_readback.sv */
`timescale 1ns/1ps

module spi_readback
  import spi_cmd_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       cmd_ready,
  input  logic       param_ready,
  input  spi_cmd_u   cmd_data,
  input  logic [7:0] param_data,
  input  logic [7:0] mcu_data_in,
  input  logic       sram_data_valid,
  output logic [7:0] spi_data_out
);

  logic strobe;

  assign strobe = cmd_ready | param_ready;

  // sram data wins over the strobe sources
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      spi_data_out <= 8'h00;
    end else if (sram_data_valid) begin
      spi_data_out <= mcu_data_in;
    end else if (strobe) begin
      case (cmd_data.opcode)
        op_signature: spi_data_out <= signature_byte;
        // echo for link testing
        op_echo:      spi_data_out <= param_data;
        default: ;
      endcase
    end
  end

endmodule

/* rtl/mcu_cmd_top.sv */
`timescale 1ns/1ps

module mcu_cmd_top
  import spi_cmd_pkg::*;
  import cart_map_pkg::*;
#(
  parameter int byte_cnt_w = 32
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   cmd_ready,
  input  logic                   param_ready,
  input  spi_cmd_u               cmd_data,
  input  logic [7:0]             param_data,
  input  logic [byte_cnt_w-1:0]  spi_byte_cnt,
  input  logic                   mcu_rq_rdy,
  input  logic [7:0]             mcu_data_in,
  output cart_cfg_t              cfg,
  output logic                   region,
  output logic                   dspx_reset,
  output dspx_load_t             dspx,
  output logic [sram_addr_w-1:0] addr_out,
  output logic                   mcu_rrq,
  output logic                   mcu_wrq,
  output logic [7:0]             mcu_data_out,
  output logic [7:0]             spi_data_out
);

  logic sram_data_valid;

  cart_config_regs #(.byte_cnt_w(byte_cnt_w)) i_cfg (
    .clk, .rst_n, .cmd_ready, .param_ready, .cmd_data, .param_data, .spi_byte_cnt,
    .cfg, .region, .dspx_reset
  );

  sram_access_ctrl #(.byte_cnt_w(byte_cnt_w)) i_sram (
    .clk, .rst_n, .cmd_ready, .param_ready, .cmd_data, .param_data, .spi_byte_cnt,
    .mcu_rq_rdy, .addr_out, .mcu_rrq, .mcu_wrq, .mcu_data_out, .sram_data_valid
  );

  dspx_loader #(.byte_cnt_w(byte_cnt_w)) i_dspx (
    .clk, .rst_n, .param_ready, .cmd_data, .param_data, .spi_byte_cnt, .dspx
  );

  spi_readback i_rdbk (
    .clk, .rst_n, .cmd_ready, .param_ready, .cmd_data, .param_data, .mcu_data_in,
    .sram_data_valid, .spi_data_out
  );

endmodule

/* sim/tb_mcu_cmd.sv */
`timescale 1ns/1ps

module tb_mcu_cmd
  import spi_cmd_pkg::*;
  import cart_map_pkg::*;
();

  // well above the length of the whole test sequence
  localparam int timeout_cycles = 2000;

  logic        clk;
  logic        rst_n;
  logic        cmd_ready;
  logic        param_ready;
  spi_cmd_u    cmd_data;
  logic [7:0]  param_data;
  logic [31:0] spi_byte_cnt;
  logic        mcu_rq_rdy;
  logic [7:0]  mcu_data_in;
  cart_cfg_t   cfg;
  logic        region;
  logic        dspx_reset;
  dspx_load_t  dspx;
  logic [23:0] addr_out;
  logic        mcu_rrq;
  logic        mcu_wrq;
  logic [7:0]  mcu_data_out;
  logic [7:0]  spi_data_out;

  logic [31:0] stim_seed;
  logic [31:0] lat_seed;
  int          cycle_cnt;

  mcu_cmd_top #(.byte_cnt_w(32)) i_dut (.*);

  initial clk = 1'b0;
  always #20 clk = ~clk;

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
      else stop_on_error($sformatf("mismatch %s expected %0h actual %0h", name, exp, act));
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [7:0] rand_byte();
    stim_seed = lcg_next(stim_seed);
    return stim_seed[23:16];
  endfunction

  // sram contents depend on every address bit
  function automatic logic [7:0] sram_pattern(input logic [23:0] a);
    return a[23:16] ^ a[15:8] ^ a[7:0] ^ 8'h5a;
  endfunction

  //////////////////////////////////////////////////
  // spi transactions
  //////////////////////////////////////////////////

  task automatic send_cmd(input logic [7:0] op);
    repeat (2) @(posedge clk);
    cmd_data.opcode <= op;
    cmd_ready       <= 1'b1;
    spi_byte_cnt    <= 32'd1;
    @(posedge clk);
    cmd_ready <= 1'b0;
    @(negedge clk);
  endtask

  task automatic send_param(input logic [7:0] b);
    repeat (2) @(posedge clk);
    param_data   <= b;
    param_ready  <= 1'b1;
    spi_byte_cnt <= spi_byte_cnt + 32'd1;
    @(posedge clk);
    param_ready <= 1'b0;
    @(negedge clk);
  endtask

  // wait for the sram answer, then two cycles for edge detect and capture
  task automatic check_read(input string name, input logic [23:0] addr, input logic autoinc);
    logic [23:0] exp_addr;
    exp_addr = autoinc ? addr + 24'd1 : addr;
    do @(negedge clk); while (!mcu_rq_rdy);
    repeat (2) @(negedge clk);
    check_val({name, " data"}, sram_pattern(addr), spi_data_out);
    check_val({name, " addr"}, exp_addr, addr_out);
  endtask

  // sram side answers a read request after 2 to 5 cycles
  initial begin : sram_model
    int          lat;
    logic [23:0] rd_addr;
    lat_seed = lcg_next(32'hbbaf);
    forever begin
      @(posedge clk);
      if (mcu_rrq) begin
        rd_addr  = addr_out;
        lat_seed = lcg_next(lat_seed);
        lat      = 2 + lat_seed[17:16];
        repeat (lat - 1) @(posedge clk);
        mcu_data_in <= sram_pattern(rd_addr);
        mcu_rq_rdy  <= 1'b1;
        @(posedge clk);
        mcu_rq_rdy <= 1'b0;
      end
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) mcu_rrq |=> !mcu_rrq)
    else stop_on_error("mcu_rrq stayed high for more than one cycle");
  assert property (@(posedge clk) disable iff (!rst_n) mcu_wrq |=> !mcu_wrq)
    else stop_on_error("mcu_wrq stayed high for more than one cycle");
  assert property (@(posedge clk) disable iff (!rst_n) $rose(mcu_wrq) |-> $past(param_ready))
    else stop_on_error("mcu_wrq rose without a param_ready strobe the cycle before");

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == timeout_cycles) begin
      stop_on_error("timeout, the tests did not finish within the cycle limit");
    end
  end

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin : main
    logic [7:0]  b0;
    logic [7:0]  b1;
    logic [7:0]  b2;
    logic [23:0] base;
    rst_n        = 1'b0;
    cmd_ready    = 1'b0;
    param_ready  = 1'b0;
    cmd_data     = '0;
    param_data   = 8'h00;
    spi_byte_cnt = 32'd0;
    mcu_rq_rdy   = 1'b0;
    mcu_data_in  = 8'h00;
    cycle_cnt    = 0;
    stim_seed    = 32'hbbaf;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);

    check_val("reset mapper", 3'd1, cfg.mapper);
    check_val("reset dspx_reset", 1'b1, dspx_reset);
    check_val("reset mcu_rrq", 1'b0, mcu_rrq);
    check_val("reset mcu_wrq", 1'b0, mcu_wrq);
    check_val("reset pgm_we", 1'b0, dspx.pgm_we);
    check_val("reset dat_we", 1'b0, dspx.dat_we);
    check_val("reset rom_mask", 24'h0, cfg.rom_mask);
    check_val("reset save_mask", 24'h0, cfg.save_mask);
    check_val("reset addr_out", 24'h0, addr_out);
    check_val("reset pgm_addr", 11'h0, dspx.pgm_addr);
    check_val("reset dat_addr", 11'h0, dspx.dat_addr);

    send_cmd(8'h35);
    check_val("mapper", 3'd5, cfg.mapper);
    send_cmd(8'h10);
    b0 = rand_byte();
    b1 = rand_byte();
    b2 = rand_byte();
    send_param(b0);
    send_param(b1);
    send_param(b2);
    check_val("rom_mask", {b0, b1, b2}, cfg.rom_mask);
    send_cmd(8'h20);
    b0 = rand_byte();
    b1 = rand_byte();
    b2 = rand_byte();
    send_param(b0);
    send_param(b1);
    send_param(b2);
    check_val("save_mask", {b0, b1, b2}, cfg.save_mask);
    send_cmd(8'hed);
    b0 = rand_byte();
    send_param(b0);
    check_val("featurebits", b0, cfg.featurebits);
    send_cmd(8'hee);
    // bit 0 set so the region register leaves its reset value
    b0 = rand_byte() | 8'h01;
    send_param(b0);
    check_val("region", b0[0], region);
    send_cmd(8'heb);
    send_param(8'h00);
    check_val("dspx_reset", 1'b0, dspx_reset);

    // address load, then reads with and without autoinc
    send_cmd(8'h00);
    b0 = rand_byte();
    b1 = rand_byte();
    b2 = rand_byte();
    send_param(b0);
    send_param(b1);
    send_param(b2);
    base = {b0, b1, b2};
    check_val("addr load", base, addr_out);
    send_cmd(8'h88);
    check_val("rrq on cmd", 1'b1, mcu_rrq);
    check_read("read cmd", base, 1'b1);
    for (int i = 0; i < 2; i++) begin
      send_param(rand_byte());
      check_val("rrq on param", 1'b1, mcu_rrq);
      check_read("read param", base + 24'd1 + 24'(i), 1'b1);
    end
    send_cmd(8'h80);
    check_val("rrq no autoinc", 1'b1, mcu_rrq);
    check_read("read hold", base + 24'd3, 1'b0);

    send_cmd(8'h98);
    b0 = rand_byte();
    send_param(b0);
    check_val("wrq", 1'b1, mcu_wrq);
    check_val("write data", b0, mcu_data_out);

    send_cmd(8'he8);
    send_param(8'h00);
    send_cmd(8'he9);
    b0 = rand_byte();
    b1 = rand_byte();
    b2 = rand_byte();
    send_param(b0);
    send_param(b1);
    send_param(b2);
    send_param(8'h00);
    check_val("pgm_we high", 1'b1, dspx.pgm_we);
    check_val("pgm_data", {b0, b1, b2}, dspx.pgm_data);
    check_val("pgm_addr before", 11'h0, dspx.pgm_addr);
    send_param(8'h00);
    check_val("pgm_we low", 1'b0, dspx.pgm_we);
    check_val("pgm_addr after", 11'h1, dspx.pgm_addr);
    send_cmd(8'hea);
    b0 = rand_byte();
    b1 = rand_byte();
    send_param(b0);
    send_param(b1);
    send_param(8'h00);
    check_val("dat_we high", 1'b1, dspx.dat_we);
    check_val("dat_data", {b0, b1}, dspx.dat_data);
    check_val("dat_addr before", 11'h0, dspx.dat_addr);
    send_param(8'h00);
    check_val("dat_we low", 1'b0, dspx.dat_we);
    check_val("dat_addr after", 11'h1, dspx.dat_addr);
    // both load addresses are nonzero here
    send_cmd(8'he8);
    send_param(8'h00);
    check_val("pgm_addr clear", 11'h0, dspx.pgm_addr);
    check_val("dat_addr clear", 11'h0, dspx.dat_addr);

    send_cmd(8'hf0);
    check_val("signature", 8'ha5, spi_data_out);
    send_cmd(8'hff);
    b0 = rand_byte();
    send_param(b0);
    check_val("echo", b0, spi_data_out);

    $display("All checks passed");
    $finish;
  end

endmodule

/* build.f */
rtl/spi_cmd_pkg.sv
rtl/cart_map_pkg.sv
rtl/cart_config_regs.sv
rtl/sram_access_ctrl.sv
rtl/dspx_loader.sv
rtl/spi_readback.sv
rtl/mcu_cmd_top.sv
sim/tb_mcu_cmd.sv

/* Bender.yml */
package:
  name: mcu_cmd

sources:
  - rtl/spi_cmd_pkg.sv
  - rtl/cart_map_pkg.sv
  - rtl/cart_config_regs.sv
  - rtl/sram_access_ctrl.sv
  - rtl/dspx_loader.sv
  - rtl/spi_readback.sv
  - rtl/mcu_cmd_top.sv
  - target: simulation
    files:
      - sim/tb_mcu_cmd.sv
